/* hdl/crtc_pkg.sv */
package crtc_pkg;

    // Register indices as seen on the write port
    typedef enum logic [4:0] {
        R0_H_TOTAL     = 5'd0,
        R1_H_DISPLAYED = 5'd1,
        R2_H_SYNC_POS  = 5'd2,
        R3_SYNC_WIDTH  = 5'd3,      // Low nibble horizontal, high nibble vertical
        R4_V_TOTAL     = 5'd4,
        R6_V_DISPLAYED = 5'd6,
        R7_V_SYNC_POS  = 5'd7,
        R9_SCAN_LINE   = 5'd9,
        R12_START_HI   = 5'd12,
        R13_START_LO   = 5'd13
    } crtc_reg_e;

    typedef enum logic [1:0] {
        ACTIVE = 2'd0,              // Visible part of the axis
        FRONT  = 2'd1,              // Blank before sync
        SYNC   = 2'd2,              // Sync pulse
        BACK   = 2'd3               // Blank after sync
    } sync_state_e;

    localparam int PIXELS_PER_CHAR = 8;
    localparam int BUS_ADDR_W      = 12;
    localparam int MA_W            = 14;

    // Roughly NTSC timing out of reset
    localparam logic [7:0] DEF_H_TOTAL     = 8'd63;
    localparam logic [7:0] DEF_H_DISPLAYED = 8'd40;
    localparam logic [7:0] DEF_H_SYNC_POS  = 8'd48;
    localparam logic [7:0] DEF_SYNC_WIDTH  = 8'h15;
    localparam logic [6:0] DEF_V_TOTAL     = 7'd32;
    localparam logic [6:0] DEF_V_DISPLAYED = 7'd25;
    localparam logic [6:0] DEF_V_SYNC_POS  = 7'd28;
    localparam logic [4:0] DEF_SCAN_LINE   = 5'd7;
    localparam logic [5:0] DEF_START_HI    = 6'h10;
    localparam logic [7:0] DEF_START_LO    = 8'h00;

endpackage

/* hdl/crtc_regs.sv */
`timescale 1ns/1ps

module crtc_regs import crtc_pkg::*; (
    input  logic            pixel_clk_i,
    input  logic            reset_i,
    input  logic            reg_wr_i,           // Write strobe, one cycle
    input  crtc_reg_e       reg_addr_i,
    input  logic [7:0]      reg_data_i,
    output logic [7:0]      h_total_o,          // Characters per line minus one
    output logic [7:0]      h_displayed_o,
    output logic [7:0]      h_sync_pos_o,
    output logic [3:0]      h_sync_width_o,     // 0 means 16
    output logic [6:0]      v_total_o,          // Rows per frame minus one
    output logic [6:0]      v_displayed_o,
    output logic [6:0]      v_sync_pos_o,
    output logic [3:0]      v_sync_width_o,
    output logic [4:0]      scan_line_o,        // Scanlines per row minus one
    output logic [MA_W-1:0] display_start_o
);
    logic [7:0] h_total_q;
    logic [7:0] h_displayed_q;
    logic [7:0] h_sync_pos_q;
    logic [7:0] sync_width_q;
    logic [6:0] v_total_q;
    logic [6:0] v_displayed_q;
    logic [6:0] v_sync_pos_q;
    logic [4:0] scan_line_q;
    logic [5:0] start_hi_q;
    logic [7:0] start_lo_q;

    always_ff @(posedge pixel_clk_i or posedge reset_i) begin
        if (reset_i) begin
            h_total_q     <= DEF_H_TOTAL;
            h_displayed_q <= DEF_H_DISPLAYED;
            h_sync_pos_q  <= DEF_H_SYNC_POS;
            sync_width_q  <= DEF_SYNC_WIDTH;
            v_total_q     <= DEF_V_TOTAL;
            v_displayed_q <= DEF_V_DISPLAYED;
            v_sync_pos_q  <= DEF_V_SYNC_POS;
            scan_line_q   <= DEF_SCAN_LINE;
            start_hi_q    <= DEF_START_HI;
            start_lo_q    <= DEF_START_LO;
        end else if (reg_wr_i) begin
            case (reg_addr_i)
                R0_H_TOTAL:     h_total_q     <= reg_data_i;
                R1_H_DISPLAYED: h_displayed_q <= reg_data_i;
                R2_H_SYNC_POS:  h_sync_pos_q  <= reg_data_i;
                R3_SYNC_WIDTH:  sync_width_q  <= reg_data_i;
                R4_V_TOTAL:     v_total_q     <= reg_data_i[6:0];
                R6_V_DISPLAYED: v_displayed_q <= reg_data_i[6:0];
                R7_V_SYNC_POS:  v_sync_pos_q  <= reg_data_i[6:0];
                R9_SCAN_LINE:   scan_line_q   <= reg_data_i[4:0];
                R12_START_HI:   start_hi_q    <= reg_data_i[5:0];
                R13_START_LO:   start_lo_q    <= reg_data_i;
                default: ;                          // Unimplemented index
            endcase
        end
    end

    assign h_total_o       = h_total_q;
    assign h_displayed_o   = h_displayed_q;
    assign h_sync_pos_o    = h_sync_pos_q;
    assign h_sync_width_o  = sync_width_q[3:0];
    assign v_total_o       = v_total_q;
    assign v_displayed_o   = v_displayed_q;
    assign v_sync_pos_o    = v_sync_pos_q;
    assign v_sync_width_o  = sync_width_q[7:4];
    assign scan_line_o     = scan_line_q;
    assign display_start_o = {start_hi_q, start_lo_q};
endmodule

/* hdl/char_timer.sv */
`timescale 1ns/1ps

module char_timer import crtc_pkg::*; (
    input  logic       pixel_clk_i,
    input  logic       reset_i,
    output logic [2:0] phase_o,         // Pixel index inside the character
    output logic       char_tick_o      // Last pixel of the character
);
    logic [2:0] phase_q;

    assign char_tick_o = (phase_q == 3'(PIXELS_PER_CHAR - 1));

    always_ff @(posedge pixel_clk_i or posedge reset_i) begin
        if (reset_i) begin
            phase_q <= '0;
        end else if (char_tick_o) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + 1'b1;
        end
    end

    assign phase_o = phase_q;
endmodule

/* hdl/sync_fsm.sv */
`timescale 1ns/1ps

module sync_fsm import crtc_pkg::*; #(
    parameter int COUNT_W = 8
) (
    input  logic               pixel_clk_i,
    input  logic               reset_i,
    input  logic               advance_i,      // One unit has ended
    input  logic [COUNT_W-1:0] total_i,        // Units per period minus one
    input  logic [COUNT_W-1:0] displayed_i,    // Visible units
    input  logic [COUNT_W-1:0] sync_pos_i,     // First sync unit
    input  logic [3:0]         sync_width_i,   // Sync length in units, 0 means 16
    output logic               active_o,
    output logic               sync_o,
    output logic               last_o          // Final unit of the period
);
    sync_state_e        state_q;
    sync_state_e        state_d;
    logic [COUNT_W-1:0] count_q;
    logic [COUNT_W-1:0] count_d;
    logic [4:0]         width;
    logic [COUNT_W:0]   sync_end;

    assign width    = (sync_width_i == 4'd0) ? 5'd16 : {1'b0, sync_width_i};
    assign sync_end = {1'b0, sync_pos_i} + {{(COUNT_W - 4){1'b0}}, width};

    // Greater-or-equal so a total lowered mid-period still wraps
    assign last_o  = (count_q >= total_i);
    assign count_d = last_o ? '0 : count_q + 1'b1;

    // Next state follows the unit that is about to start.
    // At the wrap count_d is 0, which lands back in ACTIVE
    always_comb begin
        if (count_d >= sync_pos_i && {1'b0, count_d} < sync_end) begin
            state_d = SYNC;
        end else if (count_d < displayed_i) begin
            state_d = ACTIVE;
        end else if (count_d < sync_pos_i) begin
            state_d = FRONT;
        end else begin
            state_d = BACK;
        end
    end

    always_ff @(posedge pixel_clk_i or posedge reset_i) begin
        if (reset_i) begin
            count_q <= '0;
            state_q <= ACTIVE;
        end else if (advance_i) begin
            count_q <= count_d;
            state_q <= state_d;
        end
    end

    // Moore outputs, change together with the unit counter
    assign active_o = (state_q == ACTIVE);
    assign sync_o   = (state_q == SYNC);
endmodule

/* hdl/address_counter.sv */
`timescale 1ns/1ps

module address_counter import crtc_pkg::*; (
    input  logic            pixel_clk_i,
    input  logic            reset_i,
    input  logic            char_tick_i,        // Last pixel of a character
    input  logic            line_end_i,         // In the last column of the line
    input  logic [4:0]      scan_line_i,        // Scanlines per row minus one
    input  logic [7:0]      h_displayed_i,      // Characters stored per row
    input  logic            v_last_i,           // In the last row of the frame
    input  logic [MA_W-1:0] display_start_i,
    output logic [MA_W-1:0] ma_o,
    output logic [4:0]      ra_o,
    output logic            row_end_o           // Pulse ending the last scanline of a row
);
    logic [MA_W-1:0] ma_q;
    logic [MA_W-1:0] row_start_q;
    logic [MA_W-1:0] next_row_start;
    logic [4:0]      ra_q;
    logic            line_done;
    logic            last_scan;

    assign line_done = char_tick_i & line_end_i;
    assign last_scan = (ra_q >= scan_line_i);
    assign row_end_o = line_done & last_scan;

    // A new frame starts over at display_start, otherwise step one row down
    assign next_row_start = v_last_i
        ? display_start_i
        : row_start_q + {{(MA_W - 8){1'b0}}, h_displayed_i};

    always_ff @(posedge pixel_clk_i or posedge reset_i) begin
        if (reset_i) begin
            ma_q        <= '0;
            row_start_q <= '0;
            ra_q        <= '0;
        end else if (char_tick_i) begin
            if (line_end_i) begin
                if (last_scan) begin
                    ra_q        <= '0;
                    row_start_q <= next_row_start;
                    ma_q        <= next_row_start;
                end else begin
                    ra_q <= ra_q + 1'b1;
                    ma_q <= row_start_q;    // Same characters, next glyph line
                end
            end else begin
                ma_q <= ma_q + 1'b1;
            end
        end
    end

    assign ma_o = ma_q;
    assign ra_o = ra_q;
endmodule

/* hdl/dot_shifter.sv */
`timescale 1ns/1ps

module dot_shifter import crtc_pkg::*; (
    input  logic                  pixel_clk_i,
    input  logic                  reset_i,
    input  logic [2:0]            phase_i,
    input  logic                  char_tick_i,
    input  logic [MA_W-1:0]       ma_i,
    input  logic [4:0]            ra_i,
    input  logic                  h_active_i,
    input  logic                  v_active_i,
    input  logic [7:0]            bus_data_i,
    output logic [BUS_ADDR_W-1:0] bus_addr_o,   // RAM at $000-7FF, ROM at $800-FFF
    output logic                  video_o,
    output logic                  display_enable_o
);
    logic [7:0] code_q;         // Character code of the column being fetched
    logic [7:0] glyph_q;        // Glyph line for that code
    logic [7:0] shift_q;
    logic       reverse_q;
    logic       enable_q;

    // Phase 0 reads video RAM, every later phase keeps the ROM address up
    assign bus_addr_o = (phase_i == 3'd0)
        ? {1'b0, ma_i[10:0]}
        : {2'b10, code_q[6:0], ra_i[2:0]};

    always_ff @(posedge pixel_clk_i) begin
        if (phase_i == 3'd0) begin
            code_q <= bus_data_i;
        end
        if (phase_i == 3'd1) begin
            glyph_q <= bus_data_i;
        end
    end

    // Fetched character shows during the next column, so enable
    // is sampled on the same tick to line up with it
    always_ff @(posedge pixel_clk_i or posedge reset_i) begin
        if (reset_i) begin
            shift_q   <= '0;
            reverse_q <= 1'b0;
            enable_q  <= 1'b0;
        end else if (char_tick_i) begin
            shift_q   <= glyph_q;
            reverse_q <= code_q[7];
            enable_q  <= h_active_i & v_active_i;
        end else begin
            shift_q <= {shift_q[6:0], 1'b0};   // MSB first
        end
    end

    assign video_o          = (shift_q[7] ^ reverse_q) & enable_q;
    assign display_enable_o = enable_q;
endmodule

/* hdl/video_top.sv */
`timescale 1ns/1ps

module video_top import crtc_pkg::*; #(
    parameter int H_COUNT_W = 8,
    parameter int V_COUNT_W = 7
) (
    input  logic                  pixel_clk_i,
    input  logic                  reset_i,
    input  logic                  reg_wr_i,
    input  crtc_reg_e             reg_addr_i,
    input  logic [7:0]            reg_data_i,
    input  logic [7:0]            bus_data_i,
    output logic [BUS_ADDR_W-1:0] bus_addr_o,
    output logic                  video_o,
    output logic                  display_enable_o,
    output logic                  h_sync_o,
    output logic                  v_sync_o
);
    logic [H_COUNT_W-1:0] h_total;
    logic [H_COUNT_W-1:0] h_displayed;
    logic [H_COUNT_W-1:0] h_sync_pos;
    logic [3:0]           h_sync_width;
    logic [V_COUNT_W-1:0] v_total;
    logic [V_COUNT_W-1:0] v_displayed;
    logic [V_COUNT_W-1:0] v_sync_pos;
    logic [3:0]           v_sync_width;
    logic [4:0]           scan_line;
    logic [MA_W-1:0]      display_start;
    logic [2:0]           phase;
    logic                 char_tick;
    logic                 h_active;
    logic                 h_last;
    logic                 v_active;
    logic                 v_last;
    logic                 row_end;
    logic [MA_W-1:0]      ma;
    logic [4:0]           ra;

    crtc_regs crtc_regs_i (
        .pixel_clk_i(pixel_clk_i), .reset_i(reset_i),
        .reg_wr_i(reg_wr_i), .reg_addr_i(reg_addr_i), .reg_data_i(reg_data_i),
        .h_total_o(h_total), .h_displayed_o(h_displayed),
        .h_sync_pos_o(h_sync_pos), .h_sync_width_o(h_sync_width),
        .v_total_o(v_total), .v_displayed_o(v_displayed),
        .v_sync_pos_o(v_sync_pos), .v_sync_width_o(v_sync_width),
        .scan_line_o(scan_line), .display_start_o(display_start)
    );

    char_timer char_timer_i (
        .pixel_clk_i(pixel_clk_i), .reset_i(reset_i),
        .phase_o(phase), .char_tick_o(char_tick)
    );

    // Columns step once per character
    sync_fsm #(.COUNT_W(H_COUNT_W)) h_sync_fsm (
        .pixel_clk_i(pixel_clk_i), .reset_i(reset_i), .advance_i(char_tick),
        .total_i(h_total), .displayed_i(h_displayed),
        .sync_pos_i(h_sync_pos), .sync_width_i(h_sync_width),
        .active_o(h_active), .sync_o(h_sync_o), .last_o(h_last)
    );

    // Rows step once per character row
    sync_fsm #(.COUNT_W(V_COUNT_W)) v_sync_fsm (
        .pixel_clk_i(pixel_clk_i), .reset_i(reset_i), .advance_i(row_end),
        .total_i(v_total), .displayed_i(v_displayed),
        .sync_pos_i(v_sync_pos), .sync_width_i(v_sync_width),
        .active_o(v_active), .sync_o(v_sync_o), .last_o(v_last)
    );

    address_counter address_counter_i (
        .pixel_clk_i(pixel_clk_i), .reset_i(reset_i),
        .char_tick_i(char_tick), .line_end_i(h_last),
        .scan_line_i(scan_line), .h_displayed_i(h_displayed),
        .v_last_i(v_last), .display_start_i(display_start),
        .ma_o(ma), .ra_o(ra), .row_end_o(row_end)
    );

    dot_shifter dot_shifter_i (
        .pixel_clk_i(pixel_clk_i), .reset_i(reset_i),
        .phase_i(phase), .char_tick_i(char_tick), .ma_i(ma), .ra_i(ra),
        .h_active_i(h_active), .v_active_i(v_active), .bus_data_i(bus_data_i),
        .bus_addr_o(bus_addr_o), .video_o(video_o),
        .display_enable_o(display_enable_o)
    );
endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic rst_o
);
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;      // 8 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (8) @(posedge clk_o);
        @(negedge clk_o);               // Release between edges
        rst_o = 1'b0;
    end
endmodule

/* test/video_checker.sv */
`timescale 1ns/1ps

module video_checker (
    input logic        pixel_clk_i,
    input logic        reset_i,
    input logic        video_o,
    input logic        display_enable_o,
    input logic        h_sync_o,
    input logic        v_sync_o,
    input logic [11:0] bus_addr_o,
    input logic [3:0]  h_sync_width     // Taken from inside the top level
);
    logic [7:0] hs_len;                 // Cycles of the current sync pulse
    logic [7:0] hs_expect;

    assign hs_expect = (h_sync_width == 4'd0) ? 8'd128 : {1'b0, h_sync_width, 3'b000};

    always_ff @(posedge pixel_clk_i or posedge reset_i) begin
        if (reset_i) begin
            hs_len <= '0;
        end else if (h_sync_o) begin
            hs_len <= hs_len + 8'd1;
        end else begin
            hs_len <= '0;
        end
    end

    video_needs_enable: assert property (@(posedge pixel_clk_i) disable iff (reset_i)
        video_o |-> display_enable_o)
        else $error("video_o high while display_enable_o is low");

    h_sync_length: assert property (@(posedge pixel_clk_i) disable iff (reset_i)
        $fell(h_sync_o) |-> (hs_len == hs_expect))
        else $error("h_sync_o pulse length differs from the programmed width");

    outputs_known: assert property (@(posedge pixel_clk_i) disable iff (reset_i)
        !$isunknown({video_o, display_enable_o, h_sync_o, v_sync_o, bus_addr_o}))
        else $error("DUT output is unknown after reset");
endmodule

bind video_top video_checker video_checker_i (
    .pixel_clk_i(pixel_clk_i), .reset_i(reset_i), .video_o(video_o),
    .display_enable_o(display_enable_o), .h_sync_o(h_sync_o), .v_sync_o(v_sync_o),
    .bus_addr_o(bus_addr_o), .h_sync_width(h_sync_width)
);

/* test/video_tb.sv */
`timescale 1ns/1ps

module video_tb import crtc_pkg::*; ();
    localparam int FRAME_CYCLES = 10 * 8 * 8 * 5;   // Columns, pixels, scanlines, rows
    localparam int RUN_CYCLES   = 3 * FRAME_CYCLES + 1200;

    logic       clk;
    logic       clk_rst;
    logic       tb_rst;
    logic       reset;
    logic       reg_wr;
    crtc_reg_e  reg_addr;
    logic [7:0] reg_data;
    logic [7:0] bus_data;
    logic [11:0] bus_addr;
    logic       video;
    logic       de;
    logic       hs;
    logic       vs;
    logic [7:0] vram [0:2047];
    int         cyc;                // Pixel cycle since reset release
    int         ht, hd, hp, hw, vt, vd, vp, vw, sl;
    int         new_start;          // Start address for frames 2 and up
    int         phase_no;
    bit         checking;
    int         errs [6];
    int         checks [6];
    string      names [6];

    tb_clock clock_gen (.clk_o(clk), .rst_o(clk_rst));

    assign reset = clk_rst | tb_rst;

    video_top #(.H_COUNT_W(8), .V_COUNT_W(7)) video_top_i (
        .pixel_clk_i(clk), .reset_i(reset), .reg_wr_i(reg_wr), .reg_addr_i(reg_addr),
        .reg_data_i(reg_data), .bus_data_i(bus_data), .bus_addr_o(bus_addr),
        .video_o(video), .display_enable_o(de), .h_sync_o(hs), .v_sync_o(vs)
    );

    function automatic logic [7:0] rom_byte(input logic [11:0] a);
        int v;
        v = (int'(a) * 37) ^ (int'(a) >> 3);
        return v[7:0];
    endfunction

    always_comb bus_data = bus_addr[11] ? rom_byte(bus_addr) : vram[bus_addr[10:0]];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) cyc <= 0;
        else cyc <= cyc + 1;
    end

    // Video RAM address of the character fetched in pixel cycle n
    function automatic int ram_address(input int n);
        int c;
        int line;
        int row;
        int frame;
        int start;
        c = (n / 8) % (ht + 1);
        line = n / ((ht + 1) * 8);
        row = (line / (sl + 1)) % (vt + 1);
        frame = line / ((sl + 1) * (vt + 1));
        start = (frame >= 2) ? new_start : 0;
        return (start + row * hd + c) % 2048;
    endfunction

    // Bus address in pixel cycle n, RAM in phase 0 and ROM afterwards
    function automatic logic [11:0] expected_addr(input int n);
        int ma;
        int ra;
        logic [7:0] code;
        ma = ram_address(n);
        ra = (n / ((ht + 1) * 8)) % (sl + 1);
        code = vram[ma];
        if (n % 8 == 0) begin
            return {1'b0, 11'(ma)};
        end
        return {2'b10, code[6:0], 3'(ra)};
    endfunction

    // Returns {video, display enable, h sync, v sync} for pixel cycle n
    function automatic logic [3:0] expected_out(input int n);
        int c, line, row, m, mc, mline, mrow, ma;
        logic [7:0] code;
        logic [7:0] glyph;
        logic hs_e, vs_e, de_e, vid_e;
        c = (n / 8) % (ht + 1);
        line = n / ((ht + 1) * 8);
        row = (line / (sl + 1)) % (vt + 1);
        hs_e = c >= hp && c < hp + (hw == 0 ? 16 : hw);
        vs_e = row >= vp && row < vp + (vw == 0 ? 16 : vw);
        de_e = 1'b0;
        vid_e = 1'b0;
        if (n >= 8) begin               // Shown one character after the fetch
            m = n - 8;
            mc = (m / 8) % (ht + 1);
            mline = m / ((ht + 1) * 8);
            mrow = (mline / (sl + 1)) % (vt + 1);
            de_e = mc < hd && mrow < vd;
            ma = ram_address(m);
            code = vram[ma];
            glyph = rom_byte({2'b10, code[6:0], 3'(mline % (sl + 1))});
            vid_e = de_e & (glyph[7 - n % 8] ^ code[7]);
        end
        return {vid_e, de_e, hs_e, vs_e};
    endfunction

    task automatic check_signal(input bit ok, input int cat, input string what);
        checks[cat]++;
        assert (ok) else begin
            errs[cat]++;
            $display("Fail at %0t: %s wrong in cycle %0d", $time, what, cyc);
        end
    endtask

    task automatic write_reg(input crtc_reg_e a, input logic [7:0] d);
        reg_wr = 1'b1;
        reg_addr = a;
        reg_data = d;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    task automatic report_test(input int i);
        $display("Test %0d %s: %0d checks, %0d errors, %s", i, names[i], checks[i],
                 errs[i], (errs[i] == 0) ? "ok" : "failed");
    endtask

    // Compare just after the falling edge, where outputs are settled
    initial begin
        logic [3:0] exp;
        int pix_cat;
        forever begin
            @(negedge clk);
            #1;
            if (reset && phase_no == 0) begin
                check_signal({video, de, hs, vs} == 4'b0000, 0, "output during reset");
            end else if (checking && !reset) begin
                exp = expected_out(cyc);
                pix_cat = (phase_no == 2) ? 5 : (cyc >= 2 * FRAME_CYCLES + 8) ? 4 : 3;
                check_signal(hs == exp[1], (phase_no == 2) ? 5 : 1, "h_sync_o");
                check_signal(vs == exp[0], (phase_no == 2) ? 5 : 2, "v_sync_o");
                check_signal(de == exp[2], pix_cat, "display_enable_o");
                check_signal(video == exp[3], pix_cat, "video_o");
                check_signal(bus_addr == expected_addr(cyc), pix_cat, "bus_addr_o");
            end
        end
    end

    initial begin
        #(RUN_CYCLES * 8 + 2000);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int seed;
        int total_err;
        int total_chk;
        reg_wr = 1'b0;
        reg_addr = R0_H_TOTAL;
        reg_data = 8'h00;
        tb_rst = 1'b0;
        checking = 1'b0;
        phase_no = 0;
        names = '{"reset values", "horizontal timing", "vertical timing", "pixel data",
                  "display start", "default sync and zero width"};
        seed = $urandom(32'h4483);
        for (int i = 0; i < 2048; i++) vram[i] = 8'($urandom);
        ht = 9;
        hd = 4;
        hp = 6;
        hw = 2;
        vt = 4;
        vd = 2;
        vp = 3;
        vw = 1;
        sl = 7;
        new_start = 32'h1005;

        @(negedge clk_rst);
        phase_no = 1;
        checking = 1'b1;
        report_test(0);
        write_reg(R0_H_TOTAL, 8'd9);        // All writes land inside column 0
        write_reg(R1_H_DISPLAYED, 8'd4);
        write_reg(R2_H_SYNC_POS, 8'd6);
        write_reg(R3_SYNC_WIDTH, 8'h12);
        write_reg(R4_V_TOTAL, 8'd4);
        write_reg(R6_V_DISPLAYED, 8'd2);
        write_reg(R7_V_SYNC_POS, 8'd3);
        write_reg(R9_SCAN_LINE, 8'd7);

        wait (cyc >= FRAME_CYCLES + 100);   // Mid frame 1, used from frame 2
        @(negedge clk);
        write_reg(R12_START_HI, 8'h10);
        write_reg(R13_START_LO, 8'h05);
        wait (cyc >= 3 * FRAME_CYCLES + 16);
        @(negedge clk);
        checking = 1'b0;
        for (int i = 1; i <= 4; i++) report_test(i);

        // Back to defaults with a zero horizontal width
        phase_no = 2;
        ht = 63;
        hd = 40;
        hp = 48;
        hw = 0;
        vt = 32;
        vd = 25;
        vp = 28;
        vw = 1;
        sl = 7;
        new_start = 0;
        tb_rst = 1'b1;
        repeat (2) @(negedge clk);
        tb_rst = 1'b0;
        checking = 1'b1;
        write_reg(R3_SYNC_WIDTH, 8'h10);
        wait (cyc >= 1100);
        @(negedge clk);
        checking = 1'b0;
        report_test(5);

        total_err = 0;
        total_chk = 0;
        for (int i = 0; i < 6; i++) begin
            total_err += errs[i];
            total_chk += checks[i];
        end
        $display("Checks: %0d, errors: %0d", total_chk, total_err);
        if (total_err == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end
endmodule

/* all.f */
hdl/crtc_pkg.sv
hdl/crtc_regs.sv
hdl/char_timer.sv
hdl/sync_fsm.sv
hdl/address_counter.sv
hdl/dot_shifter.sv
hdl/video_top.sv
test/tb_clock.sv
test/video_checker.sv
test/video_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the video testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module video_tb -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vvideo_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "Simulation log holds no result"
    exit 1
fi
exit 0
